/* Makefile */
# Verilator flow for the instruction cache

VERILATOR  ?= verilator
FILELIST   ?= src.f
TB_TOP     ?= tb_icache_top
RTL_TOP    ?= icache_top
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?=

SRCS    := $(wildcard src/*.sv verif/*.sv)
SIM_BIN := $(OBJ_DIR)/V$(TB_TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) --binary --timing $(SIM_FLAGS) -f $(FILELIST) \
		--top-module $(TB_TOP) --Mdir $(OBJ_DIR)

sim: $(SIM_BIN)
	$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TEST FAIL" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* src.f */
src/icache_pkg.sv
src/icache_tag_ram.sv
src/icache_data_ram.sv
src/icache_lookup.sv
src/icache_hit_check.sv
src/icache_refill.sv
src/icache_data_read.sv
src/icache_top.sv
verif/tb_mem_model.sv
verif/tb_icache_top.sv

/* src/icache_data_ram.sv */
module icache_data_ram #(
	parameter int INDEX_W  = 4,
	parameter int OFFSET_W = 4
) (
	input  logic                  clock_i,
	// read side, driven by stage 3
	input  icache_pkg::index_t    rd_index_i,
	input  logic [OFFSET_W-3:0]   rd_word_i,
	output icache_pkg::word_t     rd_data_o,
	// write side, one word per returned beat
	input  logic                  wr_i,
	input  icache_pkg::index_t    wr_index_i,
	input  logic [OFFSET_W-3:0]   wr_word_i,
	input  icache_pkg::word_t     wr_data_i
);

	////////////////////////////////////////////////////////////
	// word array, line index on top of word number
	////////////////////////////////////////////////////////////

	localparam int ADDR_BITS = INDEX_W + OFFSET_W - 2;
	localparam int DEPTH     = 2**ADDR_BITS;

	icache_pkg::word_t mem [DEPTH];

	logic [ADDR_BITS-1:0] rd_addr;
	logic [ADDR_BITS-1:0] wr_addr;

	assign rd_addr = {rd_index_i, rd_word_i};
	assign wr_addr = {wr_index_i, wr_word_i};

	// contents only matter behind a valid tag
	always_ff @(posedge clock_i)
	begin
		if (wr_i)
		begin
			mem[wr_addr] <= wr_data_i;
		end
		// registered read, old word on collision
		rd_data_o <= mem[rd_addr];
	end

endmodule

/* src/icache_data_read.sv */
module icache_data_read #(
	parameter int OFFSET_W = 4
) (
	input  logic                    clock_i,
	input  logic                    rst_n_i,
	// hit from stage 2
	input  logic                    s2_valid_i,
	input  icache_pkg::fetch_addr_t s2_addr_i,
	// word from the data ram, one cycle after the read
	input  icache_pkg::word_t       rd_data_i,
	input  logic                    clear_i,
	// data ram read
	output icache_pkg::index_t      rd_index_o,
	output logic [OFFSET_W-3:0]     rd_word_o,
	// to the core
	output logic                    instr_valid_o,
	output icache_pkg::word_t       instr_o,
	output icache_pkg::addr_t       instr_addr_o
);

	icache_pkg::fetch_addr_t s3_addr_q;

	// read the word for the stage 2 hit
	assign rd_index_o = s2_addr_i.index;
	assign rd_word_o  = s2_addr_i.offset[OFFSET_W-1:2];

	////////////////////////////////////////////////////////////
	// stage 3 register, lines up with the ram output
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			instr_valid_o <= 1'b0;
		end
		else if (clear_i)
		begin
			instr_valid_o <= 1'b0;
		end
		else
		begin
			instr_valid_o <= s2_valid_i;
		end
	end

	always_ff @(posedge clock_i)
	begin
		if (s2_valid_i)
		begin
			s3_addr_q <= s2_addr_i;
		end
	end

	// ram output register is the instruction register
	assign instr_o = rd_data_i;

	// word aligned byte address back together
	assign instr_addr_o = {s3_addr_q.tag, s3_addr_q.index,
		s3_addr_q.offset[OFFSET_W-1:2], 2'b00};

endmodule

/* src/icache_hit_check.sv */
module icache_hit_check (
	input  logic                    clock_i,
	input  logic                    rst_n_i,
	// from stage 1
	input  logic                    s1_valid_i,
	input  icache_pkg::fetch_addr_t s1_addr_i,
	// tag ram entry read at the stage 1 index
	input  icache_pkg::tag_entry_t  entry_i,
	// flush or refill resolved
	input  logic                    clear_i,
	// hit path to stage 3
	output logic                    s2_valid_o,
	output icache_pkg::fetch_addr_t s2_addr_o,
	// miss path to the refill engine
	output logic                    miss_o,
	output icache_pkg::fetch_addr_t miss_addr_o
);

	logic hit;
	logic new_miss;

	// valid bit set and tags equal
	assign hit = entry_i.valid && (entry_i.tag == s1_addr_i.tag);

	// first miss only, later ones wait for a re-issue
	assign new_miss = s1_valid_i && !hit && !miss_o;

	////////////////////////////////////////////////////////////
	// control
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			s2_valid_o <= 1'b0;
			miss_o     <= 1'b0;
		end
		else if (clear_i)
		begin
			// pipeline and miss flag both dropped
			s2_valid_o <= 1'b0;
			miss_o     <= 1'b0;
		end
		else
		begin
			s2_valid_o <= s1_valid_i && hit;
			// level, held until the refill resolves
			if (new_miss)
			begin
				miss_o <= 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// payload
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock_i)
	begin
		if (s1_valid_i && hit)
		begin
			s2_addr_o <= s1_addr_i;
		end
		// missing address kept for the refill
		if (new_miss)
		begin
			miss_addr_o <= s1_addr_i;
		end
	end

endmodule

/* src/icache_lookup.sv */
module icache_lookup (
	input  logic                    clock_i,
	input  logic                    rst_n_i,
	// fetch request from the core
	input  logic                    fetch_i,
	input  icache_pkg::addr_t       fetch_addr_i,
	// flush or refill done
	input  logic                    clear_i,
	// refill pending
	input  logic                    miss_i,
	// to stage 2
	output logic                    s1_valid_o,
	output icache_pkg::fetch_addr_t s1_addr_o,
	// tag ram read index
	output icache_pkg::index_t      tag_rd_index_o
);

	////////////////////////////////////////////////////////////
	// address split
	////////////////////////////////////////////////////////////

	icache_pkg::fetch_addr_t split;
	logic                    accept;

	// tag, index and offset straight off the address bits
	assign split = icache_pkg::fetch_addr_t'(fetch_addr_i);

	// tag read starts now, entry lands with stage 1
	assign tag_rd_index_o = split.index;

	// no new fetches while a line is missing
	assign accept = fetch_i && !miss_i;

	////////////////////////////////////////////////////////////
	// stage 1 register
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			s1_valid_o <= 1'b0;
		end
		else if (clear_i)
		begin
			// dropped, fetcher re-issues later
			s1_valid_o <= 1'b0;
		end
		else
		begin
			s1_valid_o <= accept;
		end
	end

	// address payload
	always_ff @(posedge clock_i)
	begin
		if (accept)
		begin
			s1_addr_o <= split;
		end
	end

endmodule

/* src/icache_pkg.sv */
package icache_pkg;

	////////////////////////////////////////////////////////////
	// default address split
	////////////////////////////////////////////////////////////

	// byte offset within a line, 16 byte lines
	localparam int OFFSET_W = 4;
	// 16 lines
	localparam int INDEX_W  = 4;
	localparam int ADDR_W   = 32;
	// whatever is left above index and offset
	localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;

	// fetch byte address
	typedef logic [ADDR_W-1:0]   addr_t;
	typedef logic [TAG_W-1:0]    tag_t;
	typedef logic [INDEX_W-1:0]  index_t;
	// low two bits stay zero for word fetches
	typedef logic [OFFSET_W-1:0] offset_t;
	// one instruction
	typedef logic [31:0]         word_t;

	////////////////////////////////////////////////////////////
	// stage payloads
	////////////////////////////////////////////////////////////

	// address as it travels down the pipeline, msb first
	typedef struct packed {
		tag_t    tag;
		index_t  index;
		offset_t offset;
	} fetch_addr_t;

	// tag ram word, valid bit in front of the tag
	typedef struct packed {
		logic valid;
		tag_t tag;
	} tag_entry_t;

	// refill machine
	typedef enum logic [1:0] {
		REFILL_IDLE,
		REFILL_REQUEST,
		REFILL_COLLECT,
		REFILL_COMMIT
	} refill_state_t;

endpackage

/* src/icache_refill.sv */
module icache_refill #(
	parameter int OFFSET_W = 4
) (
	input  logic                    clock_i,
	input  logic                    rst_n_i,
	// from the hit check
	input  logic                    miss_i,
	input  icache_pkg::fetch_addr_t miss_addr_i,
	// external memory return
	input  logic                    mem_rvalid_i,
	input  icache_pkg::word_t       mem_rdata_i,
	// external memory request
	output logic                    mem_req_o,
	output icache_pkg::addr_t       mem_line_addr_o,
	// data ram write
	output logic                    data_wr_o,
	output icache_pkg::index_t      data_wr_index_o,
	output logic [OFFSET_W-3:0]     data_wr_word_o,
	output icache_pkg::word_t       data_wr_data_o,
	// tag ram write
	output logic                    tag_wr_o,
	output icache_pkg::index_t      tag_wr_index_o,
	output icache_pkg::tag_entry_t  tag_wr_entry_o,
	// line is in, clears the pipeline
	output logic                    resolved_o
);

	localparam int WORD_W = OFFSET_W - 2;
	localparam int WORDS  = 2**WORD_W;

	icache_pkg::refill_state_t state_q;
	icache_pkg::refill_state_t state_d;

	logic [WORD_W-1:0]       word_cnt_q;
	icache_pkg::fetch_addr_t line_q;
	logic                    start;
	logic                    last_word;

	// miss still high in the resolved cycle, so skip it
	assign start     = (state_q == icache_pkg::REFILL_IDLE) && miss_i && !resolved_o;
	assign last_word = word_cnt_q == WORD_W'(WORDS - 1);

	////////////////////////////////////////////////////////////
	// next state
	////////////////////////////////////////////////////////////

	always_comb
	begin
		state_d = state_q;
		case (state_q)
			icache_pkg::REFILL_IDLE:
			begin
				if (start)
				begin
					state_d = icache_pkg::REFILL_REQUEST;
				end
			end
			// single request cycle
			icache_pkg::REFILL_REQUEST:
			begin
				state_d = icache_pkg::REFILL_COLLECT;
			end
			icache_pkg::REFILL_COLLECT:
			begin
				if (mem_rvalid_i && last_word)
				begin
					state_d = icache_pkg::REFILL_COMMIT;
				end
			end
			// tag write, then back to idle
			default:
			begin
				state_d = icache_pkg::REFILL_IDLE;
			end
		endcase
	end

	// state, word count and resolved pulse
	always_ff @(posedge clock_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			state_q    <= icache_pkg::REFILL_IDLE;
			word_cnt_q <= '0;
			resolved_o <= 1'b0;
		end
		else
		begin
			state_q    <= state_d;
			resolved_o <= state_q == icache_pkg::REFILL_COMMIT;
			if (state_q == icache_pkg::REFILL_REQUEST)
			begin
				word_cnt_q <= '0;
			end
			else if (data_wr_o)
			begin
				word_cnt_q <= word_cnt_q + 1'b1;
			end
		end
	end

	// line being filled, held until the next miss
	always_ff @(posedge clock_i)
	begin
		if (start)
		begin
			line_q <= miss_addr_i;
		end
	end

	////////////////////////////////////////////////////////////
	// outputs
	////////////////////////////////////////////////////////////

	assign mem_req_o       = state_q == icache_pkg::REFILL_REQUEST;
	assign mem_line_addr_o = {line_q.tag, line_q.index, {OFFSET_W{1'b0}}};

	// each word goes in as it arrives
	assign data_wr_o       = (state_q == icache_pkg::REFILL_COLLECT) && mem_rvalid_i;
	assign data_wr_index_o = line_q.index;
	assign data_wr_word_o  = word_cnt_q;
	assign data_wr_data_o  = mem_rdata_i;

	// tag goes last, line only visible once complete
	assign tag_wr_o       = state_q == icache_pkg::REFILL_COMMIT;
	assign tag_wr_index_o = line_q.index;
	assign tag_wr_entry_o = {1'b1, line_q.tag};

endmodule

/* src/icache_tag_ram.sv */
module icache_tag_ram #(
	parameter int TAG_W   = 24,
	parameter int INDEX_W = 4
) (
	input  logic                   clock_i,
	input  logic                   rst_n_i,
	// read port, index comes straight from the fetch split
	input  icache_pkg::index_t     rd_index_i,
	output icache_pkg::tag_entry_t rd_entry_o,
	// write port from the refill engine
	input  logic                   wr_i,
	input  icache_pkg::index_t     wr_index_i,
	input  icache_pkg::tag_entry_t wr_entry_i
);

	localparam int LINES = 2**INDEX_W;

	// tags live in plain storage
	logic [TAG_W-1:0] tag_mem [LINES];
	// valid bits kept apart so reset can wipe them
	logic [LINES-1:0] valid_q;

	logic [TAG_W-1:0] rd_tag_q;
	logic             rd_valid_q;

	// tag storage and its read register
	always_ff @(posedge clock_i)
	begin
		if (wr_i)
		begin
			tag_mem[wr_index_i] <= wr_entry_i.tag;
		end
		rd_tag_q <= tag_mem[rd_index_i];
	end

	// valid vector, cleared on reset
	always_ff @(posedge clock_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			valid_q    <= '0;
			rd_valid_q <= 1'b0;
		end
		else
		begin
			if (wr_i)
			begin
				valid_q[wr_index_i] <= wr_entry_i.valid;
			end
			// old value on a same-cycle write
			rd_valid_q <= valid_q[rd_index_i];
		end
	end

	// valid in front, as the hit check expects
	assign rd_entry_o = {rd_valid_q, rd_tag_q};

endmodule

/* src/icache_top.sv */
module icache_top #(
	parameter int OFFSET_W = icache_pkg::OFFSET_W,
	parameter int INDEX_W  = icache_pkg::INDEX_W,
	parameter int TAG_W    = icache_pkg::ADDR_W - INDEX_W - OFFSET_W
) (
	input  logic                  clock_i,
	input  logic                  rst_n_i,
	// core fetch side
	input  logic                  fetch_i,
	input  icache_pkg::addr_t     fetch_addr_i,
	input  logic                  flush_i,
	output logic                  instr_valid_o,
	output icache_pkg::word_t     instr_o,
	output icache_pkg::addr_t     instr_addr_o,
	output logic                  miss_o,
	// external memory side
	output logic                  mem_req_o,
	output icache_pkg::addr_t     mem_line_addr_o,
	input  logic                  mem_rvalid_i,
	input  icache_pkg::word_t     mem_rdata_i
);

	// stage 1
	logic                    s1_valid;
	icache_pkg::fetch_addr_t s1_addr;
	icache_pkg::index_t      tag_rd_index;
	icache_pkg::tag_entry_t  tag_rd_entry;
	// stage 2
	logic                    s2_valid;
	icache_pkg::fetch_addr_t s2_addr;
	icache_pkg::fetch_addr_t miss_addr;
	// stage 3 ram read
	icache_pkg::index_t      data_rd_index;
	logic [OFFSET_W-3:0]     data_rd_word;
	icache_pkg::word_t       data_rd_data;
	// refill writes
	logic                    data_wr;
	icache_pkg::index_t      data_wr_index;
	logic [OFFSET_W-3:0]     data_wr_word;
	icache_pkg::word_t       data_wr_data;
	logic                    tag_wr;
	icache_pkg::index_t      tag_wr_index;
	icache_pkg::tag_entry_t  tag_wr_entry;
	logic                    resolved;
	logic                    clear;

	////////////////////////////////////////////////////////////
	// pipeline
	////////////////////////////////////////////////////////////

	// flush or finished refill empties every stage
	assign clear = flush_i || resolved;

	icache_lookup i_lookup (
		.clock_i        (clock_i),
		.rst_n_i        (rst_n_i),
		.fetch_i        (fetch_i),
		.fetch_addr_i   (fetch_addr_i),
		.clear_i        (clear),
		.miss_i         (miss_o),
		.s1_valid_o     (s1_valid),
		.s1_addr_o      (s1_addr),
		.tag_rd_index_o (tag_rd_index)
	);

	icache_hit_check i_hit_check (
		.clock_i     (clock_i),
		.rst_n_i     (rst_n_i),
		.s1_valid_i  (s1_valid),
		.s1_addr_i   (s1_addr),
		.entry_i     (tag_rd_entry),
		.clear_i     (clear),
		.s2_valid_o  (s2_valid),
		.s2_addr_o   (s2_addr),
		.miss_o      (miss_o),
		.miss_addr_o (miss_addr)
	);

	icache_data_read #(.OFFSET_W(OFFSET_W)) i_data_read (
		.clock_i       (clock_i),
		.rst_n_i       (rst_n_i),
		.s2_valid_i    (s2_valid),
		.s2_addr_i     (s2_addr),
		.rd_data_i     (data_rd_data),
		.clear_i       (clear),
		.rd_index_o    (data_rd_index),
		.rd_word_o     (data_rd_word),
		.instr_valid_o (instr_valid_o),
		.instr_o       (instr_o),
		.instr_addr_o  (instr_addr_o)
	);

	////////////////////////////////////////////////////////////
	// storage and refill
	////////////////////////////////////////////////////////////

	icache_tag_ram #(.TAG_W(TAG_W), .INDEX_W(INDEX_W)) i_tag_ram (
		.clock_i    (clock_i),
		.rst_n_i    (rst_n_i),
		.rd_index_i (tag_rd_index),
		.rd_entry_o (tag_rd_entry),
		.wr_i       (tag_wr),
		.wr_index_i (tag_wr_index),
		.wr_entry_i (tag_wr_entry)
	);

	icache_data_ram #(.INDEX_W(INDEX_W), .OFFSET_W(OFFSET_W)) i_data_ram (
		.clock_i    (clock_i),
		.rd_index_i (data_rd_index),
		.rd_word_i  (data_rd_word),
		.rd_data_o  (data_rd_data),
		.wr_i       (data_wr),
		.wr_index_i (data_wr_index),
		.wr_word_i  (data_wr_word),
		.wr_data_i  (data_wr_data)
	);

	icache_refill #(.OFFSET_W(OFFSET_W)) i_refill (
		.clock_i         (clock_i),
		.rst_n_i         (rst_n_i),
		.miss_i          (miss_o),
		.miss_addr_i     (miss_addr),
		.mem_rvalid_i    (mem_rvalid_i),
		.mem_rdata_i     (mem_rdata_i),
		.mem_req_o       (mem_req_o),
		.mem_line_addr_o (mem_line_addr_o),
		.data_wr_o       (data_wr),
		.data_wr_index_o (data_wr_index),
		.data_wr_word_o  (data_wr_word),
		.data_wr_data_o  (data_wr_data),
		.tag_wr_o        (tag_wr),
		.tag_wr_index_o  (tag_wr_index),
		.tag_wr_entry_o  (tag_wr_entry),
		.resolved_o      (resolved)
	);

endmodule

/* verif/tb_icache_top.sv */
module tb_icache_top;

	timeunit 1ns;
	timeprecision 100ps;

	////////////////////////////////////////////////////////////
	// constants and stimulus table
	////////////////////////////////////////////////////////////

	localparam int          OFFSET_W      = icache_pkg::OFFSET_W;
	localparam int          WORDS         = 2**(OFFSET_W - 2);
	localparam logic [31:0] LINE_MASK     = ~((32'h1 << OFFSET_W) - 32'h1);
	localparam logic [31:0] DATA_MARK     = 32'h5a5a0000;
	// edges from the fetch drive edge to the result
	localparam int          HIT_LAT       = 3;
	localparam int          MISS_LAT      = 2;
	localparam int          RESULT_LIMIT  = 8;
	localparam int          REQ_LIMIT     = 8;
	localparam int          REFILL_LIMIT  = 200;
	localparam int          NUM_ROWS      = 16;

	typedef struct {
		string             name;
		icache_pkg::addr_t addr;
		logic              flush_after;
		logic              expect_miss;
	} row_t;

	row_t rows [NUM_ROWS];

	logic              clock_i;
	logic              rst_n_i;
	logic              fetch_i;
	icache_pkg::addr_t fetch_addr_i;
	logic              flush_i;
	logic              instr_valid_o;
	icache_pkg::word_t instr_o;
	icache_pkg::addr_t instr_addr_o;
	logic              miss_o;
	logic              mem_req_o;
	icache_pkg::addr_t mem_line_addr_o;
	logic              mem_rvalid_i;
	icache_pkg::word_t mem_rdata_i;

	int errors;
	int failed_tests;
	int req_count;

	icache_top i_dut (
		.clock_i         (clock_i),
		.rst_n_i         (rst_n_i),
		.fetch_i         (fetch_i),
		.fetch_addr_i    (fetch_addr_i),
		.flush_i         (flush_i),
		.instr_valid_o   (instr_valid_o),
		.instr_o         (instr_o),
		.instr_addr_o    (instr_addr_o),
		.miss_o          (miss_o),
		.mem_req_o       (mem_req_o),
		.mem_line_addr_o (mem_line_addr_o),
		.mem_rvalid_i    (mem_rvalid_i),
		.mem_rdata_i     (mem_rdata_i)
	);

	tb_mem_model #(.WORDS(WORDS)) i_mem (
		.clock_i         (clock_i),
		.mem_req_i       (mem_req_o),
		.mem_line_addr_i (mem_line_addr_o),
		.mem_rvalid_o    (mem_rvalid_i),
		.mem_rdata_o     (mem_rdata_i)
	);

	// 4 ns clock
	initial
	begin
		clock_i = 1'b0;
		forever #2 clock_i = ~clock_i;
	end

	// memory requests seen, hits must leave this alone
	always @(posedge clock_i)
	begin
		if (mem_req_o)
		begin
			req_count <= req_count + 1;
		end
	end

	////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////

	task automatic check_value(input string name, input string what,
		input logic [31:0] expected, input logic [31:0] actual);
		if (expected !== actual)
		begin
			$display("** Error: %s %s expected %h actual %h", name, what, expected, actual);
			errors++;
		end
	endtask

	task automatic report_failure(input string name, input string text);
		$display("%s: %s", name, text);
		errors++;
	endtask

	// one fetch, then watch for a hit or a miss
	task automatic run_fetch(input icache_pkg::addr_t addr, input logic flush_after,
		output int lat, output logic got_valid, output logic got_miss);
		lat       = 0;
		got_valid = 1'b0;
		got_miss  = 1'b0;
		@(posedge clock_i);
		fetch_i      <= 1'b1;
		fetch_addr_i <= addr;
		while (!got_valid && !got_miss && lat < RESULT_LIMIT)
		begin
			@(posedge clock_i);
			lat++;
			fetch_i <= 1'b0;
			// flush pulse in the cycle after the fetch
			flush_i <= flush_after && (lat == 1);
			@(negedge clock_i);
			got_valid = instr_valid_o;
			got_miss  = miss_o;
		end
	endtask

	task automatic wait_mem_req(output logic timed_out);
		int n;
		n = 0;
		while (!mem_req_o && n < REQ_LIMIT)
		begin
			@(negedge clock_i);
			n++;
		end
		timed_out = !mem_req_o;
	endtask

	// refill done once the miss level drops
	task automatic wait_miss_low(output logic timed_out);
		int n;
		n = 0;
		while (miss_o && n < REFILL_LIMIT)
		begin
			@(negedge clock_i);
			n++;
		end
		timed_out = miss_o;
	endtask

	task automatic run_row(input row_t row);
		int                lat;
		logic              got_valid;
		logic              got_miss;
		logic              timed_out;
		int                err_before;
		int                req_before;
		icache_pkg::addr_t word_addr;
		err_before = errors;
		req_before = req_count;
		word_addr  = row.addr & ~32'h3;
		run_fetch(row.addr, row.flush_after, lat, got_valid, got_miss);
		if (row.flush_after)
		begin
			// flushed fetch leaves no trace
			check_value(row.name, "flushed instr_valid", 0, got_valid);
			check_value(row.name, "flushed miss", 0, got_miss);
			run_fetch(row.addr, 1'b0, lat, got_valid, got_miss);
		end
		else
		begin
			check_value(row.name, "miss", row.expect_miss, got_miss);
			if (got_miss)
			begin
				check_value(row.name, "miss latency", MISS_LAT, lat);
				wait_mem_req(timed_out);
				if (timed_out)
				begin
					report_failure(row.name, "no memory request came after the miss");
				end
				else
				begin
					check_value(row.name, "line address", word_addr & LINE_MASK,
						mem_line_addr_o);
				end
				wait_miss_low(timed_out);
				if (timed_out)
				begin
					report_failure(row.name, "miss level never dropped, refill hung");
				end
				else
				begin
					// fetcher re-issues, line is now present
					run_fetch(row.addr, 1'b0, lat, got_valid, got_miss);
				end
			end
		end
		if (!got_valid)
		begin
			report_failure(row.name, "fetch got no instruction back in time");
		end
		else
		begin
			check_value(row.name, "hit latency", HIT_LAT, lat);
			check_value(row.name, "instr", word_addr ^ DATA_MARK, instr_o);
			check_value(row.name, "instr_addr", word_addr, instr_addr_o);
		end
		check_value(row.name, "memory requests", row.expect_miss ? 1 : 0,
			req_count - req_before);
		if (errors != err_before)
		begin
			failed_tests++;
		end
		$display("%-20s %s", row.name, (errors == err_before) ? "ok" : "FAILED");
	endtask

	////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////

	initial
	begin
		errors       = 0;
		failed_tests = 0;
		req_count    = 0;
		rst_n_i      = 1'b0;
		fetch_i      = 1'b0;
		fetch_addr_i = '0;
		flush_i      = 1'b0;
		// name, address, flush after, expect miss
		rows = '{
			'{"cold_miss",        32'h0000_1040, 1'b0, 1'b1},
			'{"same_line_off4",   32'h0000_1044, 1'b0, 1'b0},
			'{"same_line_off8",   32'h0000_1048, 1'b0, 1'b0},
			'{"same_line_offc",   32'h0000_104c, 1'b0, 1'b0},
			'{"evict_same_index", 32'h0000_2040, 1'b0, 1'b1},
			'{"refetch_evicted",  32'h0000_1040, 1'b0, 1'b1},
			'{"flush_after_hit",  32'h0000_1044, 1'b1, 1'b0},
			'{"fill_index_3",     32'h0000_3030, 1'b0, 1'b1},
			'{"fill_index_7",     32'h0000_a070, 1'b0, 1'b1},
			'{"fill_index_c",     32'h0000_50c8, 1'b0, 1'b1},
			'{"fill_index_f",     32'h7fff_f0fc, 1'b0, 1'b1},
			'{"recheck_index_3",  32'h0000_303c, 1'b0, 1'b0},
			'{"recheck_index_7",  32'h0000_a074, 1'b0, 1'b0},
			'{"recheck_index_c",  32'h0000_50c0, 1'b0, 1'b0},
			'{"recheck_index_f",  32'h7fff_f0f0, 1'b0, 1'b0},
			'{"recheck_index_4",  32'h0000_1048, 1'b0, 1'b0}
		};
		repeat (3) @(posedge clock_i);
		rst_n_i <= 1'b1;
		for (int i = 0; i < NUM_ROWS; i++)
		begin
			run_row(rows[i]);
		end
		$display("tests %0d, failed %0d, errors %0d", NUM_ROWS, failed_tests, errors);
		if (errors == 0)
		begin
			$display("TEST PASS");
		end
		else
		begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

/* verif/tb_mem_model.sv */
module tb_mem_model #(
	parameter int WORDS = 4
) (
	input  logic              clock_i,
	// request from the refill engine
	input  logic              mem_req_i,
	input  icache_pkg::addr_t mem_line_addr_i,
	// one pulse per word, in order
	output logic              mem_rvalid_o,
	output icache_pkg::word_t mem_rdata_o
);

	timeunit 1ns;
	timeprecision 100ps;

	// word data is its byte address with a marker pattern
	localparam logic [31:0] DATA_MARK = 32'h5a5a0000;

	integer            seed;
	int                gap;
	icache_pkg::addr_t line;

	initial
	begin
		seed         = 32'he521;
		mem_rvalid_o = 1'b0;
		mem_rdata_o  = '0;
		forever
		begin
			// look for a request away from the active edge
			@(negedge clock_i);
			if (mem_req_i)
			begin
				line = mem_line_addr_i;
				@(posedge clock_i);
				for (int w = 0; w < WORDS; w++)
				begin
					// 0 to 3 idle cycles in front of each word
					gap = $unsigned($random(seed)) % 4;
					if (gap != 0)
					begin
						mem_rvalid_o <= 1'b0;
						repeat (gap) @(posedge clock_i);
					end
					mem_rvalid_o <= 1'b1;
					mem_rdata_o  <= (line + 32'(4 * w)) ^ DATA_MARK;
					@(posedge clock_i);
				end
				mem_rvalid_o <= 1'b0;
			end
		end
	end

endmodule
